// ==== compile.f ====
cpu_pkg.sv
register_file.sv
main_decoder.sv
instr_queue.sv
stage_decode.sv
decode_top.sv
tb_decode.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_decode -o sim_decode
./obj_dir/sim_decode > sim.log
cat sim.log

if grep -qx "Testbench passed" sim.log; then
    echo "Simulation result: PASS"
else
    echo "Simulation result: FAIL"
    exit 1
fi

// ==== tb_decode.sv ====
`timescale 1ns/1ps

module tb_decode import cpu_pkg::*; ();

    localparam int queue_depth = 4;
    localparam int dec_credits = 2;

    // Supported opcodes and functs, followed by a few undefined ones.
    localparam logic [12:0][5:0] op_table = {op_rtype, op_j, op_jal, op_beq, op_bne, op_addi,
        op_andi, op_ori, op_lw, op_sw, 6'h01, 6'h10, 6'h3f};
    localparam logic [10:0][5:0] fn_table = {fn_add, fn_sub, fn_and, fn_or, fn_slt, fn_mult,
        fn_div, fn_mfhi, fn_mflo, 6'h01, 6'h3f};

    logic       pif;
    logic       rst_n;
    logic       fetch_valid;
    fetch_t     fetch;
    writeback_t wb;
    forward_t   forward;
    logic       dec_credit;
    logic       fetch_credit;
    logic       dec_valid;
    decoded_t   dec;

    decoded_t          expected_q[$];
    logic [31:0][31:0] shadow_regs;
    logic [31:0]       shadow_hi;
    logic [31:0]       shadow_lo;
    forward_t          cur_fwd;
    logic [31:0]       rng;
    logic [31:0]       gap_rng;
    logic              hold_credits;
    int                sent_count = 0;
    int                dec_seen = 0;
    int                credit_returns = 0;
    int                returned_dec = 0;
    int                cycles = 0;
    int                errors = 0;
    int                checks = 0;
    int                last_send_cycle = 0;
    int                last_out_cycle = 0;

    decode_top #(
        .queue_depth (queue_depth),
        .dec_credits (dec_credits)
    ) uut (
        .pif          (pif),
        .rst_n        (rst_n),
        .fetch_valid  (fetch_valid),
        .fetch        (fetch),
        .wb           (wb),
        .forward      (forward),
        .dec_credit   (dec_credit),
        .fetch_credit (fetch_credit),
        .dec_valid    (dec_valid),
        .dec          (dec)
    );

    initial pif = 1'b0;
    always #2 pif = ~pif;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic control_t expected_control(input instr_t ins);
        control_t c;
        c = '0;
        case (ins.r.opcode)
            op_rtype: begin
                case (ins.r.funct)
                    fn_add:  c.alu_op = alu_add;
                    fn_sub:  c.alu_op = alu_sub;
                    fn_and:  c.alu_op = alu_and;
                    fn_or:   c.alu_op = alu_or;
                    fn_slt:  c.alu_op = alu_slt;
                    fn_mfhi: c.alu_op = alu_mfhi;
                    fn_mflo: c.alu_op = alu_mflo;
                    fn_mult: c.alu_op = alu_mult;
                    fn_div:  c.alu_op = alu_div;
                    default: c.alu_op = alu_nop;
                endcase
                if (ins.r.funct == fn_mult || ins.r.funct == fn_div) begin
                    c.write_hi = 1'b1;
                    c.write_lo = 1'b1;
                end else if (c.alu_op != alu_nop) begin
                    c.write_reg  = 1'b1;
                    c.reg_dst_rd = 1'b1;
                end
            end
            op_addi, op_andi, op_ori, op_lw: begin
                c.write_reg   = 1'b1;
                c.alu_src_imm = 1'b1;
                c.mem_read    = (ins.i.opcode == op_lw);
                c.alu_op      = (ins.i.opcode == op_andi) ? alu_and :
                                (ins.i.opcode == op_ori) ? alu_or : alu_add;
            end
            op_sw: begin
                c.alu_op      = alu_add;
                c.alu_src_imm = 1'b1;
                c.mem_write   = 1'b1;
            end
            op_beq, op_bne: begin
                c.alu_op = alu_sub;
                c.branch = 1'b1;
            end
            op_j: c.jump = 1'b1;
            op_jal: begin
                c.jump      = 1'b1;
                c.link      = 1'b1;
                c.write_reg = 1'b1;
            end
            default: c = '0;
        endcase
        return c;
    endfunction

    function automatic decoded_t decode_ref(input instr_t ins, input logic [31:0] pc,
                                            input logic [31:0][31:0] regs,
                                            input logic [31:0] hi, input logic [31:0] lo,
                                            input forward_t fwd);
        decoded_t d;
        d.pc          = pc;
        d.pcadd4      = pc + 32'd4;
        d.pcadd8      = pc + 32'd8;
        d.pcjump      = {d.pcadd4[31:28], ins.j.target, 2'b00};
        d.instruction = ins;
        d.control     = expected_control(ins);
        d.rs          = fwd.rs.f ? fwd.rs.data : (ins.r.rs == 5'd0) ? '0 : regs[ins.r.rs];
        d.rt          = fwd.rt.f ? fwd.rt.data : (ins.r.rt == 5'd0) ? '0 : regs[ins.r.rt];
        d.hi          = fwd.hi.f ? fwd.hi.data : hi;
        d.lo          = fwd.lo.f ? fwd.lo.data : lo;
        return d;
    endfunction

    task automatic draw(output logic [31:0] v);
        rng = lcg_next(rng);
        v[31:16] = rng[31:16];
        rng = lcg_next(rng);
        v[15:0] = rng[31:16];
    endtask

    // One falling edge; inputs return to idle unless the caller drives them again.
    task automatic step();
        @(negedge pif);
        fetch_valid = 1'b0;
        wb          = '0;
    endtask

    task automatic wait_idle();
        step();
        while (expected_q.size() != 0) begin
            step();
        end
    endtask

    task automatic wait_credits_home();
        step();
        while (expected_q.size() != 0 || returned_dec != dec_seen) begin
            step();
        end
    endtask

    task automatic random_instr(output instr_t ins);
        logic [31:0] v;
        logic [31:0] k;
        draw(v);
        draw(k);
        ins = v;
        ins.r.opcode = op_table[int'(k[7:0]) % 13];
        if (ins.r.opcode == op_rtype) begin
            ins.r.funct = fn_table[int'(k[15:8]) % 11];
        end
    endtask

    task automatic send_instr(input instr_t ins);
        fetch_t      item;
        logic [31:0] pc;
        step();
        while (sent_count - credit_returns >= queue_depth) begin
            step();
        end
        draw(pc);
        item.pc          = pc;
        item.instruction = ins;
        fetch            = item;
        fetch_valid      = 1'b1;
        expected_q.push_back(decode_ref(ins, pc, shadow_regs, shadow_hi, shadow_lo, cur_fwd));
        sent_count++;
        last_send_cycle = cycles;
    endtask

    task automatic writeback(input writeback_t w);
        wait_idle();
        wb = w;
        if (w.write_reg && w.dest_reg != 5'd0) begin
            shadow_regs[w.dest_reg] = w.dest_reg_data;
        end
        if (w.write_hi) begin
            shadow_hi = w.hi_data;
        end
        if (w.write_lo) begin
            shadow_lo = w.lo_data;
        end
        step();
    endtask

    task automatic set_forward(input forward_t f);
        wait_idle();
        forward = f;
        cur_fwd = f;
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    always @(posedge pif) begin
        cycles = cycles + 1;
        if (cycles > 40 * sent_count + 200) begin
            errors++;
            $display("Timeout: run stopped after %0d cycles with %0d of %0d instructions out",
                     cycles, dec_seen, sent_count);
            $display("checks %0d, errors %0d", checks, errors);
            $display("Testbench failed");
            $finish;
        end
    end

    // Downstream credits go back at random gaps unless held.
    initial begin
        dec_credit = 1'b0;
        gap_rng    = lcg_next(32'h6416);
        forever begin
            @(negedge pif);
            dec_credit = 1'b0;
            gap_rng    = lcg_next(gap_rng);
            if (rst_n && !hold_credits && returned_dec < dec_seen && gap_rng[31]) begin
                dec_credit = 1'b1;
                returned_dec++;
            end
        end
    end

    always @(negedge pif) begin
        decoded_t e;
        if (rst_n) begin
            if (fetch_credit) begin
                credit_returns++;
            end
            if (dec_valid) begin
                dec_seen++;
                last_out_cycle = cycles;
                if (expected_q.size() == 0) begin
                    errors++;
                    $display("dec_valid at %0t with no instruction outstanding", $time);
                end else begin
                    e = expected_q.pop_front();
                    check_field("dec.pc", dec.pc, e.pc);
                    check_field("dec.pcadd4", dec.pcadd4, e.pcadd4);
                    check_field("dec.pcadd8", dec.pcadd8, e.pcadd8);
                    check_field("dec.pcjump", dec.pcjump, e.pcjump);
                    check_field("dec.instruction", dec.instruction, e.instruction);
                    check_field("dec.control", {18'd0, dec.control}, {18'd0, e.control});
                    check_field("dec.rs", dec.rs, e.rs);
                    check_field("dec.rt", dec.rt, e.rt);
                    check_field("dec.hi", dec.hi, e.hi);
                    check_field("dec.lo", dec.lo, e.lo);
                end
            end
            if (credit_returns > dec_seen) begin
                errors++;
                $display("More fetch credits returned than instructions decoded at %0t", $time);
            end
        end
    end

    initial begin
        instr_t      ins;
        writeback_t  w;
        forward_t    f;
        logic [31:0] v;
        int          base_seen;
        int          send_cycle;
        rst_n        = 1'b0;
        fetch_valid  = 1'b0;
        fetch        = '0;
        wb           = '0;
        forward      = '0;
        cur_fwd      = '0;
        shadow_regs  = '0;
        shadow_hi    = '0;
        shadow_lo    = '0;
        hold_credits = 1'b0;
        rng          = 32'h6416;
        repeat (2) @(negedge pif);
        rst_n = 1'b1;

        for (int n = 0; n < 13; n++) begin
            random_instr(ins);
            ins.r.opcode = op_table[n];
            send_instr(ins);
        end
        for (int n = 0; n < 11; n++) begin
            random_instr(ins);
            ins.r.opcode = op_rtype;
            ins.r.funct  = fn_table[n];
            send_instr(ins);
        end

        // Every register gets a value including register 0.
        for (int a = 0; a < 32; a++) begin
            draw(v);
            w               = '0;
            w.write_reg     = 1'b1;
            w.dest_reg      = 5'(a);
            w.dest_reg_data = v;
            writeback(w);
        end
        random_instr(ins);
        ins.r.rs = 5'd0;
        ins.r.rt = 5'd0;
        send_instr(ins);
        repeat (16) begin
            random_instr(ins);
            send_instr(ins);
        end

        for (int n = 0; n < 3; n++) begin
            w = '0;
            draw(v);
            w.write_hi = 1'b1;
            w.hi_data  = v;
            draw(v);
            w.write_lo = (n != 1);
            w.lo_data  = v;
            writeback(w);
            repeat (2) begin
                random_instr(ins);
                send_instr(ins);
            end
        end

        f = '0;
        draw(v);
        f.rs = {1'b1, v};
        draw(v);
        f.rt = {1'b1, v};
        draw(v);
        f.hi = {1'b1, v};
        draw(v);
        f.lo = {1'b1, v};
        set_forward(f);
        repeat (4) begin
            random_instr(ins);
            send_instr(ins);
        end
        f.rs.f = 1'b0;
        f.hi.f = 1'b0;
        set_forward(f);
        repeat (2) begin
            random_instr(ins);
            send_instr(ins);
        end
        set_forward('0);
        repeat (2) begin
            random_instr(ins);
            send_instr(ins);
        end

        repeat (60) begin
            random_instr(ins);
            send_instr(ins);
        end

        // A word into an empty queue takes one cycle to the head and one to the output register.
        wait_credits_home();
        random_instr(ins);
        send_instr(ins);
        send_cycle = last_send_cycle;
        wait_idle();
        if (last_out_cycle - send_cycle != 2) begin
            errors++;
            $display("FAILED t=%0t dec_valid latency got %0d expected 2", $time,
                     last_out_cycle - send_cycle);
        end

        wait_credits_home();
        hold_credits = 1'b1;
        base_seen    = dec_seen;
        repeat (queue_depth + dec_credits) begin
            random_instr(ins);
            send_instr(ins);
        end
        repeat (20) step();
        if (dec_seen - base_seen != dec_credits) begin
            errors++;
            $display("FAILED t=%0t dec_valid count got %0d expected %0d", $time,
                     dec_seen - base_seen, dec_credits);
        end
        hold_credits = 1'b0;

        wait_credits_home();
        if (dec_seen != sent_count) begin
            errors++;
            $display("FAILED t=%0t decoded count got %0d expected %0d", $time,
                     dec_seen, sent_count);
        end
        if (credit_returns != dec_seen) begin
            errors++;
            $display("FAILED t=%0t fetch_credit count got %0d expected %0d", $time,
                     credit_returns, dec_seen);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== decode_top.sv ====
`timescale 1ns/1ps

module decode_top import cpu_pkg::*; #(
    parameter int queue_depth = 4,
    parameter int dec_credits = 2
) (
    input  logic       pif,
    input  logic       rst_n,
    input  logic       fetch_valid,
    input  fetch_t     fetch,
    input  writeback_t wb,
    input  forward_t   forward,
    input  logic       dec_credit,
    output logic       fetch_credit,
    output logic       dec_valid,
    output decoded_t   dec
);

    logic   head_valid;
    fetch_t head;
    logic   pop;

    instr_queue #(
        .queue_depth (queue_depth)
    ) u_queue (
        .pif          (pif),
        .rst_n        (rst_n),
        .fetch_valid  (fetch_valid),
        .fetch        (fetch),
        .pop          (pop),
        .head_valid   (head_valid),
        .head         (head),
        .fetch_credit (fetch_credit)
    );

    stage_decode #(
        .dec_credits (dec_credits)
    ) u_decode (
        .pif        (pif),
        .rst_n      (rst_n),
        .head_valid (head_valid),
        .head       (head),
        .wb         (wb),
        .forward    (forward),
        .dec_credit (dec_credit),
        .pop        (pop),
        .dec_valid  (dec_valid),
        .dec        (dec)
    );

endmodule

// ==== stage_decode.sv ====
`timescale 1ns/1ps

module stage_decode import cpu_pkg::*; #(
    parameter int dec_credits = 2
) (
    input  logic       pif,
    input  logic       rst_n,
    input  logic       head_valid,
    input  fetch_t     head,
    input  writeback_t wb,
    input  forward_t   forward,
    input  logic       dec_credit,
    output logic       pop,
    output logic       dec_valid,
    output decoded_t   dec
);

    localparam int credit_w = $clog2(dec_credits + 1);

    logic [credit_w-1:0] credits;
    control_t            control;
    logic [31:0]         rs_data;
    logic [31:0]         rt_data;
    logic [31:0]         hi_reg;
    logic [31:0]         lo_reg;
    logic [31:0]         hi_value;
    logic [31:0]         lo_value;
    logic [31:0]         pcadd4;
    decoded_t            next_dec;

    function automatic logic [31:0] select_fwd(input reg_fwd_t fwd,
                                               input logic [31:0] stored);
        return fwd.f ? fwd.data : stored;
    endfunction

    main_decoder u_decoder (
        .instruction (head.instruction),
        .control     (control)
    );

    register_file u_regfile (
        .pif         (pif),
        .rst_n       (rst_n),
        .write_en    (wb.write_reg),
        .write_addr  (wb.dest_reg),
        .write_data  (wb.dest_reg_data),
        .read_addr_a (head.instruction.r.rs),
        .read_addr_b (head.instruction.r.rt),
        .read_data_a (rs_data),
        .read_data_b (rt_data)
    );

    assign pop = head_valid && (credits != '0);

    always_ff @(posedge pif or negedge rst_n) begin
        if (!rst_n) begin
            hi_reg <= '0;
            lo_reg <= '0;
        end else begin
            if (wb.write_hi) begin
                hi_reg <= wb.hi_data;
            end
            if (wb.write_lo) begin
                lo_reg <= wb.lo_data;
            end
        end
    end

    // Write-first, as in the register file.
    assign hi_value = wb.write_hi ? wb.hi_data : hi_reg;
    assign lo_value = wb.write_lo ? wb.lo_data : lo_reg;

    assign pcadd4 = head.pc + 32'd4;

    always_comb begin
        next_dec.pc          = head.pc;
        next_dec.pcadd4      = pcadd4;
        next_dec.pcadd8      = head.pc + 32'd8;
        next_dec.pcjump      = {pcadd4[31:28], head.instruction.j.target, 2'b00};
        next_dec.instruction = head.instruction;
        next_dec.control     = control;
        next_dec.rs          = select_fwd(forward.rs, rs_data);
        next_dec.rt          = select_fwd(forward.rt, rt_data);
        next_dec.hi          = select_fwd(forward.hi, hi_value);
        next_dec.lo          = select_fwd(forward.lo, lo_value);
    end

    // Credits held toward execute.
    always_ff @(posedge pif or negedge rst_n) begin
        if (!rst_n) begin
            credits <= credit_w'(dec_credits);
        end else begin
            case ({pop, dec_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge pif or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= pop;
        end
    end

    always_ff @(posedge pif) begin
        if (pop) begin
            dec <= next_dec;
        end
    end

endmodule

// ==== instr_queue.sv ====
`timescale 1ns/1ps

module instr_queue import cpu_pkg::*; #(
    parameter int queue_depth = 4
) (
    input  logic   pif,
    input  logic   rst_n,
    input  logic   fetch_valid,
    input  fetch_t fetch,
    input  logic   pop,
    output logic   head_valid,
    output fetch_t head,
    output logic   fetch_credit
);

    localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int cnt_w = $clog2(queue_depth + 1);

    fetch_t             mem [queue_depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [cnt_w-1:0]   count;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(queue_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign head_valid = (count != '0);
    assign head       = mem[rd_ptr];

    // The sender's credits keep the queue from overflowing.
    always_ff @(posedge pif) begin
        if (fetch_valid) begin
            mem[wr_ptr] <= fetch;
        end
    end

    always_ff @(posedge pif or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            fetch_credit <= 1'b0;
        end else begin
            if (fetch_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({fetch_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit goes back for every entry released.
            fetch_credit <= pop;
        end
    end

endmodule

// ==== main_decoder.sv ====
`timescale 1ns/1ps

module main_decoder import cpu_pkg::*; (
    input  instr_t   instruction,
    output control_t control
);

    logic rd_write;
    logic imm_write;
    logic hilo_write;

    always_comb begin
        control    = '0;
        rd_write   = 1'b0;
        imm_write  = 1'b0;
        hilo_write = 1'b0;
        case (instruction.i.opcode)
            op_rtype: begin
                rd_write = 1'b1;
                case (instruction.r.funct)
                    fn_add:  control.alu_op = alu_add;
                    fn_sub:  control.alu_op = alu_sub;
                    fn_and:  control.alu_op = alu_and;
                    fn_or:   control.alu_op = alu_or;
                    fn_slt:  control.alu_op = alu_slt;
                    fn_mfhi: control.alu_op = alu_mfhi;
                    fn_mflo: control.alu_op = alu_mflo;
                    fn_mult: begin
                        control.alu_op = alu_mult;
                        rd_write       = 1'b0;
                        hilo_write     = 1'b1;
                    end
                    fn_div: begin
                        control.alu_op = alu_div;
                        rd_write       = 1'b0;
                        hilo_write     = 1'b1;
                    end
                    default: rd_write = 1'b0;
                endcase
            end
            op_addi: begin
                control.alu_op = alu_add;
                imm_write      = 1'b1;
            end
            op_andi: begin
                control.alu_op = alu_and;
                imm_write      = 1'b1;
            end
            op_ori: begin
                control.alu_op = alu_or;
                imm_write      = 1'b1;
            end
            op_lw: begin
                control.alu_op   = alu_add;
                control.mem_read = 1'b1;
                imm_write        = 1'b1;
            end
            op_sw: begin
                control.alu_op      = alu_add;
                control.alu_src_imm = 1'b1;
                control.mem_write   = 1'b1;
            end
            op_beq, op_bne: begin
                // Execute compares by subtraction and reads the opcode for the sense.
                control.alu_op = alu_sub;
                control.branch = 1'b1;
            end
            op_j: begin
                control.alu_op = alu_nop;
                control.jump   = 1'b1;
            end
            op_jal: begin
                control.alu_op    = alu_nop;
                control.jump      = 1'b1;
                control.link      = 1'b1;
                control.write_reg = 1'b1;
            end
            default: control = '0;
        endcase

        if (rd_write) begin
            control.write_reg  = 1'b1;
            control.reg_dst_rd = 1'b1;
        end
        if (imm_write) begin
            control.write_reg   = 1'b1;
            control.alu_src_imm = 1'b1;
        end
        if (hilo_write) begin
            control.write_hi = 1'b1;
            control.write_lo = 1'b1;
        end
    end

endmodule

// ==== register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic        pif,
    input  logic        rst_n,
    input  logic        write_en,
    input  logic [4:0]  write_addr,
    input  logic [31:0] write_data,
    input  logic [4:0]  read_addr_a,
    input  logic [4:0]  read_addr_b,
    output logic [31:0] read_data_a,
    output logic [31:0] read_data_b
);

    logic [31:0][31:0] regs;

    // Register 0 reads as zero; a same-cycle write wins over the stored value.
    function automatic logic [31:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end
        if (write_en && write_addr == addr) begin
            return write_data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge pif or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '0;
        end else if (write_en && write_addr != 5'd0) begin
            regs[write_addr] <= write_data;
        end
    end

    assign read_data_a = read_port(read_addr_a);
    assign read_data_b = read_port(read_addr_b);

endmodule

// ==== cpu_pkg.sv ====
package cpu_pkg;

    // Instruction word formats.
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [5:0]  funct;
    } r_view_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_view_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } j_view_t;

    typedef union packed {
        r_view_t r;
        i_view_t i;
        j_view_t j;
    } instr_t;

    typedef struct packed {
        logic [3:0] alu_op;
        logic       write_reg;
        logic       reg_dst_rd;
        logic       alu_src_imm;
        logic       mem_read;
        logic       mem_write;
        logic       branch;
        logic       jump;
        logic       link;
        logic       write_hi;
        logic       write_lo;
    } control_t;

    typedef struct packed {
        logic [31:0] pc;
        instr_t      instruction;
    } fetch_t;

    // One forwarding override, f selects data over the stored value.
    typedef struct packed {
        logic        f;
        logic [31:0] data;
    } reg_fwd_t;

    typedef struct packed {
        reg_fwd_t rs;
        reg_fwd_t rt;
        reg_fwd_t hi;
        reg_fwd_t lo;
    } forward_t;

    typedef struct packed {
        logic        write_reg;
        logic [4:0]  dest_reg;
        logic [31:0] dest_reg_data;
        logic        write_hi;
        logic [31:0] hi_data;
        logic        write_lo;
        logic [31:0] lo_data;
    } writeback_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] pcadd4;
        logic [31:0] pcadd8;
        logic [31:0] pcjump;
        instr_t      instruction;
        control_t    control;
        logic [31:0] rs;
        logic [31:0] rt;
        logic [31:0] hi;
        logic [31:0] lo;
    } decoded_t;

    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_j     = 6'h02;
    localparam logic [5:0] op_jal   = 6'h03;
    localparam logic [5:0] op_beq   = 6'h04;
    localparam logic [5:0] op_bne   = 6'h05;
    localparam logic [5:0] op_addi  = 6'h08;
    localparam logic [5:0] op_andi  = 6'h0c;
    localparam logic [5:0] op_ori   = 6'h0d;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;

    localparam logic [5:0] fn_add  = 6'h20;
    localparam logic [5:0] fn_sub  = 6'h22;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_mult = 6'h18;
    localparam logic [5:0] fn_div  = 6'h1a;
    localparam logic [5:0] fn_mfhi = 6'h10;
    localparam logic [5:0] fn_mflo = 6'h12;

    localparam logic [3:0] alu_nop  = 4'd0;
    localparam logic [3:0] alu_add  = 4'd1;
    localparam logic [3:0] alu_sub  = 4'd2;
    localparam logic [3:0] alu_and  = 4'd3;
    localparam logic [3:0] alu_or   = 4'd4;
    localparam logic [3:0] alu_slt  = 4'd5;
    localparam logic [3:0] alu_mult = 4'd6;
    localparam logic [3:0] alu_div  = 4'd7;
    localparam logic [3:0] alu_mfhi = 4'd8;
    localparam logic [3:0] alu_mflo = 4'd9;

endpackage
